// ==== include/rename_cfg.svh ====
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// rename stage sizing

`define ARCH_REGS 32  // x0..x31
`define PHYS_REGS 64  // physical register pool

`define ARCH_W 5      // log2 of ARCH_REGS
`define PHYS_W 6      // log2 of PHYS_REGS

// free list starts with every tag above the identity mapping,
// so PHYS_REGS must exceed ARCH_REGS

`endif

// ==== source/rename_pkg.sv ====
`include "rename_cfg.svh"

package rename_pkg;

    typedef logic [`ARCH_W-1:0] arch_reg_t;  // architectural register index
    typedef logic [`PHYS_W-1:0] phys_tag_t;  // physical register tag

    // rv32 major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    typedef enum logic {
        prefer_alu  = 1'b0,
        prefer_load = 1'b1
    } arb_state_t;

    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } rename_req_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        logic [1:0] src_ready;  // bit 0 is rs1, bit 1 is rs2
        phys_tag_t rd_tag;
        arch_reg_t rd_arch;
        phys_tag_t old_tag;     // mapping that rd replaced
        logic      old_valid;
    } rename_rsp_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t arch;
        phys_tag_t tag;
    } wb_t;

endpackage

// ==== source/rename_table.sv ====
`include "rename_cfg.svh"

module rename_table import rename_pkg::*; (
    input  logic        write_enable,
    input  logic        reset,
    input  rename_req_t req,
    input  wb_t         wakeup,
    input  phys_tag_t   free_tag,
    input  logic        free_empty,
    output logic        pop,
    output logic        push,
    output phys_tag_t   push_tag,
    output logic        stall,
    output rename_rsp_t rsp
);

    phys_tag_t             map [`ARCH_REGS];  // alias table
    logic [`ARCH_REGS-1:0] ready;             // per architectural register

    logic       writes_rd;
    logic       accept;
    logic       wake_hit;
    logic       rdy1;
    logic       rdy2;
    logic [1:0] src_ready;
    phys_tag_t  tag1;
    phys_tag_t  tag2;
    phys_tag_t  old_tag;

    // x0 never gets a new tag
    assign writes_rd = (req.opcode != op_branch) && (req.opcode != op_store)
                       && (req.rd != '0);

    assign stall  = req.valid && writes_rd && free_empty;
    assign accept = req.valid && !stall;

    assign tag1    = map[req.rs1];
    assign tag2    = map[req.rs2];
    assign old_tag = map[req.rd];

    // only a writeback of the live mapping counts
    assign wake_hit = wakeup.valid && (map[wakeup.arch] == wakeup.tag);

    // same-cycle wakeup bypass
    assign rdy1 = ready[req.rs1] || (wake_hit && (wakeup.arch == req.rs1));
    assign rdy2 = ready[req.rs2] || (wake_hit && (wakeup.arch == req.rs2));

    always_comb begin
        case (req.opcode)
            op_lui, op_auipc, op_jal: begin
                src_ready = 2'b11;              // no register sources
            end
            op_jalr, op_load, op_imm: begin
                src_ready = {1'b1, rdy1};       // rs1 only
            end
            default: begin
                src_ready = {rdy2, rdy1};
            end
        endcase
    end

    // old tag goes straight back to the free list
    assign pop      = accept && writes_rd;
    assign push     = pop;
    assign push_tag = old_tag;

    always_ff @(posedge write_enable) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= phys_tag_t'(i);  // identity mapping
            end
            ready <= '1;
        end else begin
            if (wake_hit) begin
                ready[wakeup.arch] <= 1'b1;
            end
            // rename after wakeup so a new mapping starts not ready
            if (pop) begin
                map[req.rd]   <= free_tag;
                ready[req.rd] <= 1'b0;
            end
        end
    end

    always_ff @(posedge write_enable) begin
        if (reset) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= accept;
        end
        if (accept) begin
            rsp.src1_tag  <= tag1;
            rsp.src2_tag  <= tag2;
            rsp.src_ready <= src_ready;
            rsp.rd_tag    <= free_tag;   // meaningful with old_valid
            rsp.rd_arch   <= req.rd;
            rsp.old_tag   <= old_tag;
            rsp.old_valid <= writes_rd;
        end
    end

endmodule

// ==== source/free_list.sv ====
`include "rename_cfg.svh"

module free_list import rename_pkg::*; (
    input  logic      write_enable,
    input  logic      reset,
    input  logic      pop,
    input  logic      push,
    input  phys_tag_t push_tag,
    output phys_tag_t head_tag,
    output logic      empty
);

    localparam int DEPTH = `PHYS_REGS;
    localparam int INIT  = `PHYS_REGS - `ARCH_REGS;  // tags free after reset
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    phys_tag_t        mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [PTR_W-1:0] head_next;
    logic [PTR_W-1:0] tail_next;

    // wrap without relying on a power of two depth
    assign head_next = (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
    assign tail_next = (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;

    assign head_tag = mem[head];
    assign empty    = (count == '0);

    always_ff @(posedge write_enable) begin
        if (reset) begin
            for (int i = 0; i < INIT; i++) begin
                mem[i] <= phys_tag_t'(`ARCH_REGS + i);  // 32..63 in order
            end
            head  <= '0;
            tail  <= PTR_W'(INIT);
            count <= CNT_W'(INIT);
        end else begin
            if (push) begin
                mem[tail] <= push_tag;
                tail      <= tail_next;
            end
            if (pop) begin
                head <= head_next;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or swap
            endcase
        end
    end

endmodule

// ==== source/wb_arbiter.sv ====
module wb_arbiter import rename_pkg::*; (
    input  logic write_enable,
    input  logic reset,
    input  wb_t  alu_wb,
    input  wb_t  load_wb,
    output logic alu_grant,
    output logic load_grant,
    output wb_t  wakeup
);

    arb_state_t prio;
    logic       contend;

    assign contend = alu_wb.valid && load_wb.valid;

    // a lone requester always wins
    assign alu_grant  = alu_wb.valid && (!load_wb.valid || prio == prefer_alu);
    assign load_grant = load_wb.valid && (!alu_wb.valid || prio == prefer_load);

    always_comb begin
        if (alu_grant) begin
            wakeup = alu_wb;
        end else if (load_grant) begin
            wakeup = load_wb;
        end else begin
            wakeup = '0;  // idle bus
        end
    end

    // priority moves only on a real conflict
    always_ff @(posedge write_enable) begin
        if (reset) begin
            prio <= prefer_alu;
        end else if (contend) begin
            prio <= (prio == prefer_alu) ? prefer_load : prefer_alu;
        end
    end

endmodule

// ==== source/rename_unit.sv ====
module rename_unit import rename_pkg::*; (
    input  logic        write_enable,
    input  logic        reset,
    input  rename_req_t req,
    input  wb_t         alu_wb,
    input  wb_t         load_wb,
    output logic        stall,
    output rename_rsp_t rsp,
    output logic        alu_grant,
    output logic        load_grant
);

    phys_tag_t free_tag;
    logic      free_empty;
    logic      pop;
    logic      push;
    phys_tag_t push_tag;
    wb_t       wakeup;  // arbitrated writeback

    rename_table u_table (
        .write_enable (write_enable),
        .reset        (reset),
        .req          (req),
        .wakeup       (wakeup),
        .free_tag     (free_tag),
        .free_empty   (free_empty),
        .pop          (pop),
        .push         (push),
        .push_tag     (push_tag),
        .stall        (stall),
        .rsp          (rsp)
    );

    free_list u_free_list (
        .write_enable (write_enable),
        .reset        (reset),
        .pop          (pop),
        .push         (push),
        .push_tag     (push_tag),
        .head_tag     (free_tag),
        .empty        (free_empty)
    );

    wb_arbiter u_wb_arbiter (
        .write_enable (write_enable),
        .reset        (reset),
        .alu_wb       (alu_wb),
        .load_wb      (load_wb),
        .alu_grant    (alu_grant),
        .load_grant   (load_grant),
        .wakeup       (wakeup)
    );

endmodule

// ==== dv/rename_assertions.sv ====
module rename_assertions import rename_pkg::*; (
    input logic        write_enable,
    input logic        reset,
    input rename_req_t req,
    input logic        stall,
    input rename_rsp_t rsp,
    input logic        alu_grant,
    input logic        load_grant,
    input logic        pop,
    input logic        free_empty
);
    timeunit 1ns;
    timeprecision 100ps;

    logic accept;

    assign accept = req.valid && !stall;

    // response comes exactly one edge after acceptance
    accept_to_rsp: assert property (@(posedge write_enable) disable iff (reset)
        accept |=> rsp.valid)
        else $error("rsp.valid missing one cycle after an accepted request");

    no_spurious_rsp: assert property (@(posedge write_enable) disable iff (reset)
        !accept |=> !rsp.valid)
        else $error("rsp.valid without an accepted request");

    one_grant: assert property (@(posedge write_enable) disable iff (reset)
        !(alu_grant && load_grant))
        else $error("alu_grant and load_grant high together");

    no_pop_empty: assert property (@(posedge write_enable) disable iff (reset)
        free_empty |-> !pop)
        else $error("pop while the free list is empty");

endmodule

// ==== dv/rename_tb.sv ====
`include "rename_cfg.svh"

module rename_tb import rename_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [3:0]  test;
        rename_req_t req;
        wb_t         alu;
        wb_t         load;
    } row_t;

    localparam int ROWS        = 21;
    localparam int STALL_LIMIT = 8;
    localparam int DRAIN_LIMIT = 16;

    logic        write_enable;
    logic        reset;
    rename_req_t req;
    wb_t         alu_wb;
    wb_t         load_wb;
    logic        stall;
    rename_rsp_t rsp;
    logic        alu_grant;
    logic        load_grant;

    row_t        rows [ROWS];
    string       names [1:6];
    phys_tag_t   map_m [`ARCH_REGS];  // shadow alias table
    logic        rdy_m [`ARCH_REGS];
    phys_tag_t   free_q [$];         // shadow free list
    wb_t         alu_q [$];          // writebacks held until granted
    wb_t         load_q [$];
    logic        prio_load;          // 1 when load has priority
    rename_rsp_t exp_rsp;
    integer      seed = 39779;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;

    rename_unit dut (
        .write_enable (write_enable),
        .reset        (reset),
        .req          (req),
        .alu_wb       (alu_wb),
        .load_wb      (load_wb),
        .stall        (stall),
        .rsp          (rsp),
        .alu_grant    (alu_grant),
        .load_grant   (load_grant)
    );

    bind rename_unit rename_assertions u_assertions (
        .write_enable (write_enable),
        .reset        (reset),
        .req          (req),
        .stall        (stall),
        .rsp          (rsp),
        .alu_grant    (alu_grant),
        .load_grant   (load_grant),
        .pop          (pop),
        .free_empty   (free_empty)
    );

    always #2 write_enable = ~write_enable;

    function automatic rename_req_t make_req(input opcode_t op, input int rd,
                                             input int rs1, input int rs2);
        rename_req_t r;
        r.valid  = 1'b1;
        r.opcode = op;
        r.rd     = arch_reg_t'(rd);
        r.rs1    = arch_reg_t'(rs1);
        r.rs2    = arch_reg_t'(rs2);
        return r;
    endfunction

    function automatic wb_t make_wb(input int arch, input int tag);
        wb_t w;
        w.valid = 1'b1;
        w.arch  = arch_reg_t'(arch);
        w.tag   = phys_tag_t'(tag);
        return w;
    endfunction

    task automatic build_rows();
        names[1] = "reset mapping";
        names[2] = "rename chain";
        names[3] = "opcode readiness";
        names[4] = "wakeup";
        names[5] = "arbitration";
        names[6] = "free list recycling";
        rows[0]  = '{4'd1, make_req(op_reg, 1, 5, 9), '0, '0};
        rows[1]  = '{4'd2, make_req(op_imm, 3, 0, 0), '0, '0};
        rows[2]  = '{4'd2, make_req(op_imm, 3, 0, 0), '0, '0};
        rows[3]  = '{4'd2, make_req(op_reg, 4, 3, 3), '0, '0};     // x3 newest is 34
        rows[4]  = '{4'd3, make_req(op_lui, 5, 3, 4), '0, '0};
        rows[5]  = '{4'd3, make_req(op_jal, 6, 3, 4), '0, '0};
        rows[6]  = '{4'd3, make_req(op_load, 7, 3, 4), '0, '0};
        rows[7]  = '{4'd3, make_req(op_branch, 8, 3, 4), '0, '0};  // no pop
        rows[8]  = '{4'd3, make_req(op_store, 9, 4, 1), '0, '0};
        rows[9]  = '{4'd3, make_req(op_reg, 0, 1, 2), '0, '0};     // x0 stays put
        rows[10] = '{4'd3, make_req(op_jalr, 0, 3, 4), '0, '0};
        rows[11] = '{4'd3, make_req(op_auipc, 0, 3, 4), '0, '0};
        rows[12] = '{4'd4, make_req(op_reg, 10, 3, 1), make_wb(3, 34), '0};  // forwarded
        rows[13] = '{4'd4, make_req(op_reg, 11, 3, 4), make_wb(4, 4), '0};   // stale tag
        rows[14] = '{4'd4, make_req(op_reg, 12, 4, 1), '0, make_wb(1, 32)};
        rows[15] = '{4'd4, make_req(op_reg, 13, 1, 4), '0, '0};
        rows[16] = '{4'd5, '0, make_wb(4, 35), make_wb(10, 39)};
        rows[17] = '{4'd5, '0, make_wb(11, 40), make_wb(12, 41)};
        rows[18] = '{4'd5, '0, make_wb(13, 42), '0};
        rows[19] = '{4'd5, '0, '0, '0};
        rows[20] = '{4'd5, make_req(op_reg, 14, 4, 13), '0, '0};
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rsp();
        check_value("rsp.valid", rsp.valid, exp_rsp.valid);
        if (exp_rsp.valid) begin
            check_value("rsp.src1_tag", rsp.src1_tag, exp_rsp.src1_tag);
            check_value("rsp.src2_tag", rsp.src2_tag, exp_rsp.src2_tag);
            check_value("rsp.src_ready", rsp.src_ready, exp_rsp.src_ready);
            check_value("rsp.rd_arch", rsp.rd_arch, exp_rsp.rd_arch);
            check_value("rsp.old_valid", rsp.old_valid, exp_rsp.old_valid);
            if (exp_rsp.old_valid) begin
                check_value("rsp.rd_tag", rsp.rd_tag, exp_rsp.rd_tag);
                check_value("rsp.old_tag", rsp.old_tag, exp_rsp.old_tag);
            end
        end
    endtask

    // one clock of stimulus, with the expected outcome of the next edge
    task automatic run_cycle(input rename_req_t r, output logic stalled);
        wb_t  wb_a;
        wb_t  wb_l;
        wb_t  wake;
        logic g_alu;
        logic g_load;
        logic writes;
        logic wake_ok;
        logic r1;
        logic r2;
        @(negedge write_enable);
        check_rsp();
        wb_a    = (alu_q.size() > 0) ? alu_q[0] : '0;
        wb_l    = (load_q.size() > 0) ? load_q[0] : '0;
        req     = r;
        alu_wb  = wb_a;
        load_wb = wb_l;
        #1;
        g_alu  = wb_a.valid && (!wb_l.valid || !prio_load);
        g_load = wb_l.valid && (!wb_a.valid || prio_load);
        check_value("alu_grant", alu_grant, g_alu);
        check_value("load_grant", load_grant, g_load);
        wake    = g_alu ? wb_a : (g_load ? wb_l : '0);
        writes  = (r.opcode != op_branch) && (r.opcode != op_store) && (r.rd != '0);
        stalled = r.valid && writes && (free_q.size() == 0);
        check_value("stall", stall, stalled);
        wake_ok = wake.valid && (map_m[wake.arch] == wake.tag);
        r1 = rdy_m[r.rs1] || (wake_ok && (wake.arch == r.rs1));
        r2 = rdy_m[r.rs2] || (wake_ok && (wake.arch == r.rs2));
        exp_rsp           = '0;
        exp_rsp.valid     = r.valid && !stalled;
        exp_rsp.src1_tag  = map_m[r.rs1];
        exp_rsp.src2_tag  = map_m[r.rs2];
        exp_rsp.rd_arch   = r.rd;
        exp_rsp.old_valid = writes;
        exp_rsp.old_tag   = map_m[r.rd];
        case (r.opcode)
            op_lui, op_auipc, op_jal: exp_rsp.src_ready = 2'b11;
            op_jalr, op_load, op_imm: exp_rsp.src_ready = {1'b1, r1};
            default:                  exp_rsp.src_ready = {r2, r1};
        endcase
        if (wake_ok) begin
            rdy_m[wake.arch] = 1'b1;
        end
        if (exp_rsp.valid && writes) begin
            exp_rsp.rd_tag = free_q.pop_front();
            map_m[r.rd]    = exp_rsp.rd_tag;
            rdy_m[r.rd]    = 1'b0;
            free_q.push_back(exp_rsp.old_tag);  // no commit, released at once
        end
        if (wb_a.valid && wb_l.valid) begin
            prio_load = !prio_load;
        end
        // a source holds its writeback until the DUT grants it
        if (alu_grant === 1'b1 && wb_a.valid) begin
            void'(alu_q.pop_front());
        end
        if (load_grant === 1'b1 && wb_l.valid) begin
            void'(load_q.pop_front());
        end
    endtask

    task automatic apply_request(input rename_req_t r);
        logic stalled;
        int   tries;
        tries   = 0;
        stalled = 1'b1;
        while (stalled && tries < STALL_LIMIT) begin
            run_cycle(r, stalled);
            tries++;
        end
        if (stalled) begin
            $display("request still stalled after %0d cycles", STALL_LIMIT);
            errors++;
        end
    endtask

    task automatic report_test(input int id);
        $display("test %0d %s: %0d checks, %0d failed", id, names[id],
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    initial begin
        int          n;
        logic        last;
        rename_req_t r;
        write_enable = 1'b0;
        reset        = 1'b1;
        req          = '0;
        alu_wb       = '0;
        load_wb      = '0;
        prio_load    = 1'b0;
        exp_rsp      = '0;
        checks       = 0;
        errors       = 0;
        test_checks  = 0;
        test_errors  = 0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            map_m[i] = phys_tag_t'(i);
            rdy_m[i] = 1'b1;
        end
        for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
            free_q.push_back(phys_tag_t'(i));
        end
        build_rows();
        repeat (2) @(posedge write_enable);
        @(negedge write_enable);
        reset = 1'b0;

        for (int i = 0; i < ROWS; i++) begin
            if (rows[i].alu.valid) begin
                alu_q.push_back(rows[i].alu);
            end
            if (rows[i].load.valid) begin
                load_q.push_back(rows[i].load);
            end
            apply_request(rows[i].req);
            last = (i == ROWS - 1) ? 1'b1 : (rows[i + 1].test != rows[i].test);
            if (last) begin
                apply_request('0);  // collects the response of the last row
                report_test(rows[i].test);
            end
        end

        n = 0;
        while ((alu_q.size() > 0 || load_q.size() > 0) && n < DRAIN_LIMIT) begin
            apply_request('0);
            n++;
        end
        if (alu_q.size() > 0 || load_q.size() > 0) begin
            $display("held writebacks not granted within %0d cycles", DRAIN_LIMIT);
            errors++;
        end

        // old tags recycle in the same cycle, so the list never runs dry
        for (int i = 0; i < 36; i++) begin
            r = make_req(op_reg, 1 + ($unsigned($random(seed)) % 31),
                         $unsigned($random(seed)) % 32, $unsigned($random(seed)) % 32);
            apply_request(r);
        end
        apply_request(make_req(op_store, 0, 3, 4));  // no rd
        apply_request(make_req(op_branch, 7, 1, 2));
        apply_request('0);
        report_test(6);

        $display("total: %0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
source/rename_pkg.sv
source/rename_table.sv
source/free_list.sv
source/wb_arbiter.sv
source/rename_unit.sv
dv/rename_assertions.sv
dv/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_unit

export_include_dirs:
  - include

sources:
  - files:
      - source/rename_pkg.sv
      - source/rename_table.sv
      - source/free_list.sv
      - source/wb_arbiter.sv
      - source/rename_unit.sv
  - target: dv
    files:
      - dv/rename_assertions.sv
      - dv/rename_tb.sv
